/* logic/decode_stage.sv */
// Decode stage with register file, immediates, control decode, load-use stall and ID/EX register
`timescale 1ns/1ps

module decode_stage (
	input  logic i_clk,
	input  logic i_rst_n,
	fd_if.decode fd,
	de_if.decode de,
	wb_if.decode wb
);
	import rv_pkg::*;

	instr_u               ins;
	logic [6:0]           opcode;
	logic [RF_ADDR_W-1:0] rs1;
	logic [RF_ADDR_W-1:0] rs2;
	logic [RF_ADDR_W-1:0] rd;
	logic [XLEN-1:0]      imm_i;
	logic [XLEN-1:0]      imm_s;
	logic [XLEN-1:0]      imm_u;
	logic [XLEN-1:0]      imm;
	logic [XLEN-1:0]      rs1_val;
	logic [XLEN-1:0]      rs2_val;
	logic [ALU_OP_W-1:0]  alu_op;
	logic                 use_imm;
	logic                 mem_read;
	logic                 mem_write;
	logic                 reg_write;
	logic [WB_SEL_W-1:0]  wb_sel;
	logic                 uses_rs1;
	logic                 uses_rs2;
	logic                 bubble;
	logic [XLEN-1:0]      regs [32];

	// ALU function from funct3, sub only for register form
	function automatic logic [ALU_OP_W-1:0] alu_decode(input logic [2:0] f3, input logic sub);
		logic [ALU_OP_W-1:0] op;
		case (f3)
			F3_ADD_SUB: op = sub ? ALU_SUB : ALU_ADD;
			F3_SLL:     op = ALU_SLL;
			F3_SLT:     op = ALU_SLT;
			F3_XOR:     op = ALU_XOR;
			F3_SRL:     op = ALU_SRL;
			F3_OR:      op = ALU_OR;
			F3_AND:     op = ALU_AND;
			default:    op = ALU_ADD;
		endcase
		return op;
	endfunction

	// Register fields through the R view
	assign ins    = fd.instr;
	assign opcode = ins.r_view.opcode;
	assign rs1    = ins.r_view.rs1;
	assign rs2    = ins.r_view.rs2;
	assign rd     = ins.r_view.rd;

	// Immediates through the I/S view
	assign imm_i = {{20{ins.is_view.imm_hi[6]}}, ins.is_view.imm_hi, ins.is_view.rs2_or_imm_lo};
	assign imm_s = {{20{ins.is_view.imm_hi[6]}}, ins.is_view.imm_hi, ins.is_view.rd_or_imm_lo};
	assign imm_u = {ins.is_view.imm_hi, ins.is_view.rs2_or_imm_lo, ins.is_view.rs1,
		ins.is_view.funct3, 12'h000};

	// Control decode, unknown opcodes retire as no-ops
	always_comb begin
		alu_op    = ALU_ADD;
		use_imm   = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		wb_sel    = WB_ALU;
		imm       = imm_i;
		case (opcode)
			OP_R: begin
				reg_write = 1'b1;
				alu_op    = alu_decode(ins.r_view.funct3, ins.r_view.funct7 == F7_SUB);
			end
			OP_IMM: begin
				reg_write = 1'b1;
				use_imm   = 1'b1;
				alu_op    = alu_decode(ins.r_view.funct3, 1'b0);
			end
			OP_LOAD: begin
				reg_write = 1'b1;
				use_imm   = 1'b1;
				mem_read  = 1'b1;
				wb_sel    = WB_MEM;
			end
			OP_STORE: begin
				use_imm   = 1'b1;
				mem_write = 1'b1;
				imm       = imm_s;
			end
			OP_LUI: begin
				reg_write = 1'b1;
				wb_sel    = WB_IMM;
				imm       = imm_u;
			end
			default: begin
				reg_write = 1'b0;
			end
		endcase
	end

	// Register file, x0 stays zero since writeback never targets it
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// Reads see a write landing on this same edge
	assign rs1_val = (rs1 == '0) ? '0 : (wb.valid && wb.rd == rs1) ? wb.data : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : (wb.valid && wb.rd == rs2) ? wb.data : regs[rs2];

	// Load-use check against the entry now in ID/EX
	assign uses_rs1 = (opcode != OP_LUI);
	assign uses_rs2 = (opcode == OP_R) || (opcode == OP_STORE);
	assign fd.stall = fd.valid && de.valid && de.mem_read && (de.rd != '0) &&
		((uses_rs1 && de.rd == rs1) || (uses_rs2 && de.rd == rs2));

	// Stall or empty IF/ID sends a bubble
	assign bubble = fd.stall || !fd.valid;

	// ID/EX control
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			de.valid     <= 1'b0;
			de.mem_read  <= 1'b0;
			de.mem_write <= 1'b0;
			de.reg_write <= 1'b0;
		end else begin
			de.valid     <= !bubble;
			de.mem_read  <= !bubble && mem_read;
			de.mem_write <= !bubble && mem_write;
			de.reg_write <= !bubble && reg_write;
		end
	end

	// ID/EX payload
	always_ff @(posedge i_clk) begin
		de.pc      <= fd.pc;
		de.rs1     <= rs1;
		de.rs2     <= rs2;
		de.rd      <= rd;
		de.rs1_val <= rs1_val;
		de.rs2_val <= rs2_val;
		de.imm     <= imm;
		de.alu_op  <= alu_op;
		de.use_imm <= use_imm;
		de.wb_sel  <= wb_sel;
	end

	// Memory stage must filter x0 and non-writing instructions
	a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		wb.valid |-> wb.rd != '0);

	// Only a load in ID/EX may hold the front end, and the hold lasts one cycle
	a_stall_on_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		fd.stall |-> (de.wb_sel == WB_MEM && de.reg_write) ##1 !fd.stall);

endmodule

/* logic/execute_stage.sv */
// Execute stage with operand forwarding, the ALU and the EX/MEM register
`timescale 1ns/1ps

module execute_stage (
	input  logic  i_clk,
	input  logic  i_rst_n,
	de_if.execute de,
	em_if.execute em,
	wb_if.execute wb
);
	import rv_pkg::*;

	logic [XLEN-1:0] em_fwd_val;
	logic            fwd_a_em;
	logic            fwd_a_wb;
	logic            fwd_b_em;
	logic            fwd_b_wb;
	logic [XLEN-1:0] src_a;
	logic [XLEN-1:0] fwd_b;
	logic [XLEN-1:0] src_b;
	logic [XLEN-1:0] alu_result;

	// Value the EX/MEM entry will write back, loads never reach here thanks to the stall
	assign em_fwd_val = (em.wb_sel == WB_IMM) ? em.imm : em.alu_result;

	// Match against EX/MEM, x0 excluded
	assign fwd_a_em = em.valid && em.reg_write && (em.rd != '0) && (em.rd == de.rs1);
	assign fwd_b_em = em.valid && em.reg_write && (em.rd != '0) && (em.rd == de.rs2);
	// Match against MEM/WB, already qualified upstream
	assign fwd_a_wb = wb.valid && (wb.rd == de.rs1);
	assign fwd_b_wb = wb.valid && (wb.rd == de.rs2);

	// Youngest writer wins
	assign src_a = fwd_a_em ? em_fwd_val : fwd_a_wb ? wb.data : de.rs1_val;
	assign fwd_b = fwd_b_em ? em_fwd_val : fwd_b_wb ? wb.data : de.rs2_val;
	// Immediate for I type, load and store addresses
	assign src_b = de.use_imm ? de.imm : fwd_b;

	always_comb begin
		case (de.alu_op)
			ALU_ADD: alu_result = src_a + src_b;
			ALU_SUB: alu_result = src_a - src_b;
			ALU_AND: alu_result = src_a & src_b;
			ALU_OR:  alu_result = src_a | src_b;
			ALU_XOR: alu_result = src_a ^ src_b;
			// Signed compare
			ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
			// Shift amount from the low five bits
			ALU_SLL: alu_result = src_a << src_b[4:0];
			ALU_SRL: alu_result = src_a >> src_b[4:0];
			default: alu_result = src_a + src_b;
		endcase
	end

	// EX/MEM control
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			em.valid     <= 1'b0;
			em.mem_read  <= 1'b0;
			em.mem_write <= 1'b0;
			em.reg_write <= 1'b0;
		end else begin
			em.valid     <= de.valid;
			em.mem_read  <= de.mem_read;
			em.mem_write <= de.mem_write;
			em.reg_write <= de.reg_write;
		end
	end

	// EX/MEM payload, store data carries the forwarded rs2
	always_ff @(posedge i_clk) begin
		em.rd         <= de.rd;
		em.alu_result <= alu_result;
		em.store_data <= fwd_b;
		em.imm        <= de.imm;
		em.wb_sel     <= de.wb_sel;
	end

	// When both stages match, the winning EX/MEM entry is never a load still waiting on memory
	a_fwd_priority: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(de.valid && fwd_a_em && fwd_a_wb) |-> !em.mem_read)
		else $error("forwarding priority broken at pc %h", de.pc);

endmodule

/* logic/fetch_stage.sv */
// Fetch stage holding the PC and the IF/ID register, fed by an external instruction source
`timescale 1ns/1ps

module fetch_stage #(
	parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic [rv_pkg::XLEN-1:0] i_instr,
	output logic [rv_pkg::XLEN-1:0] o_pc,
	fd_if.fetch                     fd
);

	logic [rv_pkg::XLEN-1:0] pc;

	// PC advances one word unless decode holds it
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pc <= RESET_PC;
		end else if (!fd.stall) begin
			pc <= pc + 'd4;
		end
	end

	assign o_pc = pc;

	// IF/ID valid, set from the first edge after reset
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			fd.valid <= 1'b0;
		end else if (!fd.stall) begin
			fd.valid <= 1'b1;
		end
	end

	// IF/ID payload, frozen during a stall
	always_ff @(posedge i_clk) begin
		if (!fd.stall) begin
			fd.pc    <= pc;
			fd.instr <= i_instr;
		end
	end

	// No branches in this core so fetch stays on word boundaries
	a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_pc[1:0] == 2'b00);

endmodule

/* logic/memory_stage.sv */
// Memory stage with the word data RAM, writeback select and the MEM/WB register
`timescale 1ns/1ps

module memory_stage #(
	parameter int DMEM_ADDR_W = 6
) (
	input  logic i_clk,
	input  logic i_rst_n,
	em_if.memory em,
	wb_if.memory wb
);
	import rv_pkg::*;

	logic [XLEN-1:0]        ram [2**DMEM_ADDR_W];
	logic [DMEM_ADDR_W-1:0] word_addr;
	logic [XLEN-1:0]        load_data;
	logic [XLEN-1:0]        wb_val;

	// Word index from the byte address
	assign word_addr = em.alu_result[DMEM_ADDR_W+1:2];

	// Synchronous write
	always_ff @(posedge i_clk) begin
		if (em.valid && em.mem_write) begin
			ram[word_addr] <= em.store_data;
		end
	end

	// Asynchronous read
	assign load_data = ram[word_addr];

	always_comb begin
		case (em.wb_sel)
			WB_MEM:  wb_val = load_data;
			WB_IMM:  wb_val = em.imm;
			default: wb_val = em.alu_result;
		endcase
	end

	// MEM/WB valid only for a real register write
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= em.valid && em.reg_write && (em.rd != '0);
		end
	end

	// MEM/WB payload
	always_ff @(posedge i_clk) begin
		wb.rd   <= em.rd;
		wb.data <= wb_val;
	end

	// Only word accesses exist
	a_word_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(em.valid && (em.mem_read || em.mem_write)) |-> em.alu_result[1:0] == 2'b00);

endmodule

/* logic/pipe_ifs.sv */
// Stage to stage bundles of the pipeline, one interface per boundary with a modport per side
`timescale 1ns/1ps

// IF/ID register contents plus the stall level back to fetch
interface fd_if;
	import rv_pkg::*;

	logic            valid;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] instr;
	// Load-use hold, driven by decode
	logic            stall;

	modport fetch (output valid, pc, instr, input stall);
	modport decode (input valid, pc, instr, output stall);
endinterface

// ID/EX register contents
interface de_if;
	import rv_pkg::*;

	logic                 valid;
	logic [XLEN-1:0]      pc;
	logic [RF_ADDR_W-1:0] rs1;
	logic [RF_ADDR_W-1:0] rs2;
	logic [RF_ADDR_W-1:0] rd;
	logic [XLEN-1:0]      rs1_val;
	logic [XLEN-1:0]      rs2_val;
	logic [XLEN-1:0]      imm;
	logic [ALU_OP_W-1:0]  alu_op;
	// ALU operand B from the immediate
	logic                 use_imm;
	logic                 mem_read;
	logic                 mem_write;
	logic                 reg_write;
	logic [WB_SEL_W-1:0]  wb_sel;

	modport decode (output valid, pc, rs1, rs2, rd, rs1_val, rs2_val, imm, alu_op,
		use_imm, mem_read, mem_write, reg_write, wb_sel);
	modport execute (input valid, pc, rs1, rs2, rd, rs1_val, rs2_val, imm, alu_op,
		use_imm, mem_read, mem_write, reg_write, wb_sel);
endinterface

// EX/MEM register contents
interface em_if;
	import rv_pkg::*;

	logic                 valid;
	logic [RF_ADDR_W-1:0] rd;
	logic [XLEN-1:0]      alu_result;
	logic [XLEN-1:0]      store_data;
	// Kept for lui writeback
	logic [XLEN-1:0]      imm;
	logic                 mem_read;
	logic                 mem_write;
	logic                 reg_write;
	logic [WB_SEL_W-1:0]  wb_sel;

	modport execute (output valid, rd, alu_result, store_data, imm, mem_read, mem_write,
		reg_write, wb_sel);
	modport memory (input valid, rd, alu_result, store_data, imm, mem_read, mem_write,
		reg_write, wb_sel);
endinterface

// MEM/WB register contents, already qualified for a real register write
interface wb_if;
	import rv_pkg::*;

	logic                 valid;
	logic [RF_ADDR_W-1:0] rd;
	logic [XLEN-1:0]      data;

	modport memory (output valid, rd, data);
	modport decode (input valid, rd, data);
	modport execute (input valid, rd, data);
endinterface

/* logic/risc_v_top.sv */
// Top level of the five stage RV32I subset core, instruction supply and retire strobe on plain ports
`timescale 1ns/1ps

module risc_v_top #(
	parameter logic [rv_pkg::XLEN-1:0] RESET_PC    = '0,
	parameter int                      DMEM_ADDR_W = 6
) (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	// Instruction word for o_pc
	input  logic [rv_pkg::XLEN-1:0]      i_instr,
	output logic [rv_pkg::XLEN-1:0]      o_pc,
	// One pulse per retiring register write
	output logic                         o_wb_valid,
	output logic [rv_pkg::RF_ADDR_W-1:0] o_wb_rd,
	output logic [rv_pkg::XLEN-1:0]      o_wb_data
);

	fd_if fd_bus ();
	de_if de_bus ();
	em_if em_bus ();
	wb_if wb_bus ();

	fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_instr (i_instr),
		.o_pc    (o_pc),
		.fd      (fd_bus.fetch)
	);

	decode_stage decode_stage_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.fd      (fd_bus.decode),
		.de      (de_bus.decode),
		.wb      (wb_bus.decode)
	);

	execute_stage execute_stage_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.de      (de_bus.execute),
		.em      (em_bus.execute),
		.wb      (wb_bus.execute)
	);

	memory_stage #(.DMEM_ADDR_W(DMEM_ADDR_W)) memory_stage_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.em      (em_bus.memory),
		.wb      (wb_bus.memory)
	);

	// Retire strobe straight from MEM/WB
	assign o_wb_valid = wb_bus.valid;
	assign o_wb_rd    = wb_bus.rd;
	assign o_wb_data  = wb_bus.data;

endmodule

/* logic/rv_pkg.sv */
// Shared RV32I encodings, ALU and writeback codes and the instruction word views for the pipeline
package rv_pkg;

	// Data and address width
	localparam int XLEN = 32;
	// Register number width
	localparam int RF_ADDR_W = 5;

	// Opcodes kept in the subset
	localparam logic [6:0] OP_R     = 7'b0110011;
	localparam logic [6:0] OP_IMM   = 7'b0010011;
	localparam logic [6:0] OP_LOAD  = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_LUI   = 7'b0110111;

	// Funct3 values of the ALU group
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL     = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	// Funct7 that turns add into sub
	localparam logic [6:0] F7_SUB = 7'b0100000;

	// ALU operation codes, produced in decode
	localparam int ALU_OP_W = 4;
	localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR  = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd7;

	// Writeback source select
	localparam int WB_SEL_W = 2;
	localparam logic [WB_SEL_W-1:0] WB_ALU = 2'd0;
	localparam logic [WB_SEL_W-1:0] WB_MEM = 2'd1;
	localparam logic [WB_SEL_W-1:0] WB_IMM = 2'd2;

	// R format view, used for register fields
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	// I/S format view, used for immediate fields
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2_or_imm_lo;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd_or_imm_lo;
		logic [6:0] opcode;
	} is_fmt_t;

	// Same instruction word, two decodings
	typedef union packed {
		r_fmt_t  r_view;
		is_fmt_t is_view;
	} instr_u;

endpackage

/* tb.f */
+incdir+test
logic/rv_pkg.sv
logic/pipe_ifs.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/risc_v_top.sv
test/tb_risc_v_top.sv

/* test/tb_program.svh */
// Directed program rows with hand-derived retire register and value, included in the testbench
task automatic load_directed_program();
	// Immediates, sign extension and upper immediates
	add_row(enc_i(OP_IMM, 3'b000, 5'd1, 5'd0, 12'h064), 5'd1, 32'h0000_0064, T_IMM);
	add_row(enc_i(OP_IMM, 3'b000, 5'd2, 5'd0, 12'hFF9), 5'd2, 32'hFFFF_FFF9, T_IMM);
	add_row(enc_u(5'd3, 20'h12345), 5'd3, 32'h1234_5000, T_IMM);
	add_row(enc_i(OP_IMM, 3'b110, 5'd4, 5'd3, 12'h678), 5'd4, 32'h1234_5678, T_IMM);
	add_row(enc_i(OP_IMM, 3'b100, 5'd5, 5'd2, 12'h0F0), 5'd5, 32'hFFFF_FF09, T_IMM);
	add_row(enc_i(OP_IMM, 3'b111, 5'd6, 5'd4, 12'hF00), 5'd6, 32'h1234_5600, T_IMM);
	// Negative compare, -7 < -6
	add_row(enc_i(OP_IMM, 3'b010, 5'd7, 5'd2, 12'hFFA), 5'd7, 32'h0000_0001, T_IMM);
	add_row(enc_i(OP_IMM, 3'b010, 5'd8, 5'd1, 12'hFFF), 5'd8, 32'h0000_0000, T_IMM);
	add_row(enc_u(5'd9, 20'hFFFFF), 5'd9, 32'hFFFF_F000, T_IMM);

	// Chain, each op reads the result just before it
	add_row(enc_r(3'b000, 1'b0, 5'd10, 5'd1, 5'd4), 5'd10, 32'h1234_56DC, T_FWD);
	add_row(enc_r(3'b000, 1'b1, 5'd11, 5'd10, 5'd1), 5'd11, 32'h1234_5678, T_FWD);
	add_row(enc_r(3'b111, 1'b0, 5'd12, 5'd11, 5'd9), 5'd12, 32'h1234_5000, T_FWD);
	add_row(enc_r(3'b110, 1'b0, 5'd13, 5'd12, 5'd1), 5'd13, 32'h1234_5064, T_FWD);
	add_row(enc_r(3'b100, 1'b0, 5'd14, 5'd13, 5'd4), 5'd14, 32'h0000_061C, T_FWD);
	add_row(enc_r(3'b010, 1'b0, 5'd15, 5'd2, 5'd14), 5'd15, 32'h0000_0001, T_FWD);
	add_row(enc_r(3'b001, 1'b0, 5'd16, 5'd14, 5'd15), 5'd16, 32'h0000_0C38, T_FWD);
	// Shift amount 24 taken from the low bits of x16
	add_row(enc_r(3'b101, 1'b0, 5'd17, 5'd9, 5'd16), 5'd17, 32'h0000_00FF, T_FWD);
	add_row(enc_r(3'b000, 1'b1, 5'd18, 5'd17, 5'd2), 5'd18, 32'h0000_0106, T_FWD);

	// Store then load, dependent use right after each load
	add_row(enc_i(OP_IMM, 3'b000, 5'd19, 5'd0, 12'h040), 5'd19, 32'h0000_0040, T_MEM);
	add_row(enc_s(5'd18, 5'd19, 12'h008), 5'd0, 32'h0, T_MEM);
	add_row(enc_i(OP_LOAD, 3'b010, 5'd20, 5'd19, 12'h008), 5'd20, 32'h0000_0106, T_MEM);
	add_row(enc_r(3'b000, 1'b0, 5'd21, 5'd20, 5'd1), 5'd21, 32'h0000_016A, T_MEM);
	add_row(enc_i(OP_IMM, 3'b000, 5'd22, 5'd21, 12'h001), 5'd22, 32'h0000_016B, T_MEM);
	// Negative store offset, forwarded store data
	add_row(enc_s(5'd22, 5'd19, 12'hFFC), 5'd0, 32'h0, T_MEM);
	add_row(enc_i(OP_LOAD, 3'b010, 5'd23, 5'd19, 12'hFFC), 5'd23, 32'h0000_016B, T_MEM);
	add_row(enc_r(3'b000, 1'b1, 5'd24, 5'd0, 5'd23), 5'd24, 32'hFFFF_FE95, T_MEM);
	// Load with its use two slots later, no stall
	add_row(enc_i(OP_LOAD, 3'b010, 5'd27, 5'd19, 12'h008), 5'd27, 32'h0000_0106, T_MEM);
	add_row(enc_i(OP_IMM, 3'b000, 5'd28, 5'd0, 12'h003), 5'd28, 32'h0000_0003, T_MEM);
	add_row(enc_r(3'b000, 1'b0, 5'd29, 5'd27, 5'd28), 5'd29, 32'h0000_0109, T_MEM);

	// Writes to x0 retire silently, x0 reads stay zero
	add_row(enc_i(OP_IMM, 3'b000, 5'd0, 5'd1, 12'h037), 5'd0, 32'h0, T_X0);
	add_row(enc_r(3'b000, 1'b0, 5'd0, 5'd4, 5'd4), 5'd0, 32'h0, T_X0);
	add_row(enc_r(3'b000, 1'b0, 5'd25, 5'd0, 5'd1), 5'd25, 32'h0000_0064, T_X0);
	add_row(enc_u(5'd0, 20'hABCDE), 5'd0, 32'h0, T_X0);
	add_row(enc_r(3'b110, 1'b0, 5'd26, 5'd0, 5'd0), 5'd26, 32'h0000_0000, T_X0);
endtask

/* test/tb_risc_v_top.sv */
// Testbench for the pipeline top, supplies instructions by o_pc and checks every retirement
`timescale 1ns/1ps

module tb_risc_v_top;
	import rv_pkg::*;

	localparam logic [31:0] RESET_PC       = 32'h0;
	localparam int          DMEM_ADDR_W    = 6;
	localparam int          CLK_PERIOD     = 40;
	localparam int          RETIRE_TIMEOUT = 20;
	localparam int          TRAIL_CYCLES   = 12;
	localparam int          RANDOM_ROWS    = 40;
	localparam logic [31:0] NOP            = 32'h0000_0013;
	// Test ids
	localparam int T_RESET = 0;
	localparam int T_IMM   = 1;
	localparam int T_FWD   = 2;
	localparam int T_MEM   = 3;
	localparam int T_X0    = 4;
	localparam int T_RAND  = 5;
	// Funct3 per random kind, add sub and or xor slt sll srl then addi andi ori xori slti
	localparam logic [23:0] R_F3 = {3'b101, 3'b001, 3'b010, 3'b100, 3'b110, 3'b111, 3'b000, 3'b000};
	localparam logic [14:0] I_F3 = {3'b010, 3'b100, 3'b110, 3'b111, 3'b000};

	logic        i_clk;
	logic        i_rst_n;
	logic [31:0] i_instr;
	logic [31:0] o_pc;
	logic        o_wb_valid;
	logic [4:0]  o_wb_rd;
	logic [31:0] o_wb_data;

	// Program and expected retirements in order
	logic [31:0] prog [$];
	logic [4:0]  exp_rd [$];
	logic [31:0] exp_val [$];
	int          exp_cycle [$];
	int          exp_test [$];
	// Reference architectural state
	logic [31:0] mregs [32];
	logic [31:0] mmem [2**DMEM_ADDR_W];
	int          stalls = 0;
	logic [4:0]  prev_load_rd = 5'd0;
	int          cycle = 0;
	integer      seed = 16504;
	int          test_checks [6];
	int          test_errs [6];
	int          misc_errs = 0;

	risc_v_top #(.RESET_PC(RESET_PC), .DMEM_ADDR_W(DMEM_ADDR_W)) risc_v_top_i (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_instr    (i_instr),
		.o_pc       (o_pc),
		.o_wb_valid (o_wb_valid),
		.o_wb_rd    (o_wb_rd),
		.o_wb_data  (o_wb_data)
	);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	// Edges counted from reset release, edge 1 latches the first fetch
	always @(posedge i_clk) begin
		if (i_rst_n) begin
			cycle <= cycle + 1;
		end
	end

	function automatic string name_of(input int t);
		case (t)
			T_RESET: return "reset";
			T_IMM:   return "immediates";
			T_FWD:   return "forwarding";
			T_MEM:   return "memory and load-use";
			T_X0:    return "x0 handling";
			default: return "random program";
		endcase
	endfunction

	function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic sub,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {(sub ? 7'b0100000 : 7'b0000000), rs2, rs1, f3, rd, OP_R};
	endfunction

	function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, OP_LUI};
	endfunction

	// ISA semantics of the kept ALU functions
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return sub ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b101:  return a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	// Does this instruction read register r as a source
	function automatic bit reads_reg(input logic [31:0] ins, input logic [4:0] r);
		bit use1;
		bit use2;
		use1 = (ins[6:0] != OP_LUI);
		use2 = (ins[6:0] == OP_R) || (ins[6:0] == OP_STORE);
		return (use1 && ins[19:15] == r) || (use2 && ins[24:20] == r);
	endfunction

	function automatic logic [31:0] fetch_word(input logic [31:0] pc);
		int idx;
		idx = (pc - RESET_PC) >> 2;
		return (idx < prog.size()) ? prog[idx] : NOP;
	endfunction

	// One instruction through the reference model, updates model state
	task automatic model_exec(input logic [31:0] ins, output logic [4:0] rd,
		output logic [31:0] val, output bit ret);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] addr;
		rd    = ins[11:7];
		a     = mregs[ins[19:15]];
		b     = mregs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		val   = '0;
		ret   = 1'b0;
		case (ins[6:0])
			OP_R: begin
				val = alu_ref(ins[14:12], ins[30], a, b);
				ret = 1'b1;
			end
			OP_IMM: begin
				val = alu_ref(ins[14:12], 1'b0, a, imm_i);
				ret = 1'b1;
			end
			OP_LOAD: begin
				addr = a + imm_i;
				val  = mmem[addr[DMEM_ADDR_W+1:2]];
				ret  = 1'b1;
			end
			OP_STORE: begin
				addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				mmem[addr[DMEM_ADDR_W+1:2]] = b;
			end
			OP_LUI: begin
				val = {ins[31:12], 12'h000};
				ret = 1'b1;
			end
			default: begin
				ret = 1'b0;
			end
		endcase
		if (rd == 5'd0) begin
			ret = 1'b0;
		end
		if (ret) begin
			mregs[rd] = val;
		end
	endtask

	// Appends a row, a load-use pair pushes later retirements back one cycle
	task automatic queue_row(input logic [31:0] ins, input logic [4:0] rd,
		input logic [31:0] val, input bit ret, input int test);
		int k;
		k = prog.size();
		if (prev_load_rd != 5'd0 && reads_reg(ins, prev_load_rd)) begin
			stalls++;
		end
		prog.push_back(ins);
		if (ret) begin
			exp_rd.push_back(rd);
			exp_val.push_back(val);
			exp_cycle.push_back(k + 4 + stalls);
			exp_test.push_back(test);
		end
		prev_load_rd = (ins[6:0] == OP_LOAD) ? ins[11:7] : 5'd0;
	endtask

	// Directed row, table value cross-checked with the model
	task automatic add_row(input logic [31:0] ins, input logic [4:0] rd,
		input logic [31:0] val, input int test);
		logic [4:0]  m_rd;
		logic [31:0] m_val;
		bit          m_ret;
		model_exec(ins, m_rd, m_val, m_ret);
		if (m_ret != (rd != 5'd0) || (m_ret && (m_rd !== rd || m_val !== val))) begin
			$display("program row %0d of test %s disagrees with the reference model",
				prog.size(), name_of(test));
			test_errs[test]++;
		end
		queue_row(ins, rd, val, rd != 5'd0, test);
	endtask

	task automatic add_random_row();
		logic [31:0] rnd;
		logic [31:0] rnd2;
		logic [31:0] ins;
		logic [4:0]  m_rd;
		logic [31:0] m_val;
		bit          m_ret;
		int          kind;
		rnd  = $random(seed);
		rnd2 = $random(seed);
		kind = rnd2 % 14;
		if (kind < 8) begin
			ins = enc_r(R_F3[kind*3 +: 3], kind == 1, rnd[4:0], rnd[9:5], rnd[14:10]);
		end else if (kind < 13) begin
			ins = enc_i(OP_IMM, I_F3[(kind-8)*3 +: 3], rnd[4:0], rnd[9:5], rnd[26:15]);
		end else begin
			ins = enc_u(rnd[4:0], rnd2[31:12]);
		end
		model_exec(ins, m_rd, m_val, m_ret);
		queue_row(ins, m_rd, m_val, m_ret, T_RAND);
	endtask

	`include "tb_program.svh"

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp, input int test);
		$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		test_errs[test]++;
	endtask

	// PC and retire strobe while nothing can have retired yet
	task automatic check_front(input logic [31:0] exp_pc);
		test_checks[T_RESET] += 2;
		if (o_pc !== exp_pc) begin
			report_mismatch("o_pc", o_pc, exp_pc, T_RESET);
		end
		if (o_wb_valid !== 1'b0) begin
			report_mismatch("o_wb_valid", {31'b0, o_wb_valid}, 32'h0, T_RESET);
		end
	endtask

	task automatic print_test_line(input int t);
		$display("test %s: %0d checks, %0d errors", name_of(t), test_checks[t], test_errs[t]);
	endtask

	// Next retire strobe, sampled mid-cycle
	task automatic wait_retire(output logic [4:0] rd, output logic [31:0] data,
		output int at_cycle, output bit ok);
		int waited;
		ok       = 1'b0;
		waited   = 0;
		rd       = '0;
		data     = '0;
		at_cycle = 0;
		while (!ok && waited < RETIRE_TIMEOUT) begin
			@(negedge i_clk);
			waited++;
			if (o_wb_valid === 1'b1) begin
				ok       = 1'b1;
				rd       = o_wb_rd;
				data     = o_wb_data;
				at_cycle = cycle;
			end
		end
	endtask

	// Instruction for the current PC, a little after each edge
	initial begin
		i_instr = NOP;
		forever begin
			@(posedge i_clk);
			#1;
			i_instr = fetch_word(o_pc);
		end
	end

	initial begin
		logic [4:0]  got_rd;
		logic [31:0] got_data;
		int          got_cycle;
		bit          ok;
		bit          timed_out;
		int          t;
		int          total_checks;
		int          total_errs;
		i_rst_n   = 1'b0;
		timed_out = 1'b0;
		for (int i = 0; i < 32; i++) begin
			mregs[i] = '0;
		end
		for (int i = 0; i < 6; i++) begin
			test_checks[i] = 0;
			test_errs[i]   = 0;
		end
		load_directed_program();
		for (int i = 0; i < RANDOM_ROWS; i++) begin
			add_random_row();
		end

		// Two reset edges, then release clear of the edge
		@(negedge i_clk);
		check_front(RESET_PC);
		@(posedge i_clk);
		#1;
		i_rst_n = 1'b1;
		@(negedge i_clk);
		check_front(RESET_PC);
		for (int n = 1; n <= 3; n++) begin
			@(negedge i_clk);
			check_front(RESET_PC + 4 * n);
		end
		print_test_line(T_RESET);

		// Retirements in program order, each with value and cycle
		for (int i = 0; i < exp_rd.size(); i++) begin
			wait_retire(got_rd, got_data, got_cycle, ok);
			if (!ok) begin
				$display("timeout: retirement %0d of x%0d never arrived", i, exp_rd[i]);
				misc_errs++;
				timed_out = 1'b1;
				break;
			end
			t = exp_test[i];
			test_checks[t] += 3;
			if (got_rd !== exp_rd[i]) begin
				report_mismatch("o_wb_rd", {27'b0, got_rd}, {27'b0, exp_rd[i]}, t);
			end
			if (got_data !== exp_val[i]) begin
				report_mismatch("o_wb_data", got_data, exp_val[i], t);
			end
			if (got_cycle != exp_cycle[i]) begin
				report_mismatch("retire cycle", got_cycle, exp_cycle[i], t);
			end
			if (i == exp_rd.size() - 1 || exp_test[i+1] != t) begin
				print_test_line(t);
			end
		end

		// Only NOPs follow, nothing more may retire
		if (!timed_out) begin
			for (int n = 0; n < TRAIL_CYCLES; n++) begin
				@(negedge i_clk);
				if (o_wb_valid === 1'b1) begin
					$display("unexpected retirement of x%0d after the program ended", o_wb_rd);
					misc_errs++;
				end
			end
		end

		total_checks = 0;
		total_errs   = misc_errs;
		for (int i = 0; i < 6; i++) begin
			total_checks += test_checks[i];
			total_errs   += test_errs[i];
		end
		$display("summary: %0d checks, %0d errors", total_checks, total_errs);
		if (total_errs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
